//--- Makefile
# Verilator flow for the posit16 multiply unit

TOP = positMulUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

# the run passes only if the pass message shows up in the output
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -Mdir obj_dir -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- rtl/positCompose.sv
`timescale 1ns/1ps

module positCompose (
  input  positPkg::product_t prodFields,
  output positPkg::posit_t   word
);

  // normalization
  logic carry;
  logic [positPkg::prodFracWidth-1:0] frac;
  logic signed [positPkg::scaleWidth:0] normScale;
  logic signed [positPkg::scaleWidth-1:0] clampScale;
  // regime encoding
  logic signed [positPkg::scaleWidth-1:0] regime;
  logic regBit;
  logic [positPkg::scaleWidth-1:0] shiftAmt;
  logic signed [positPkg::composeTop:0] strBase;
  logic signed [positPkg::composeTop:0] strShift;
  // rounding
  logic [positPkg::positWidth-2:0] body;
  logic guard;
  logic sticky;
  logic roundUp;
  logic [positPkg::positWidth-2:0] rounded;
  logic [positPkg::positWidth-1:0] magnitude;

  // ==========================================================
  // normalize, product of two or more moves one place right
  // ==========================================================
  assign carry = prodFields.prod[2*positPkg::sigWidth-1];
  assign frac = carry ? prodFields.prod[positPkg::prodFracWidth-1:0]
                      : {prodFields.prod[positPkg::prodFracWidth-2:0], 1'b0};
  assign normScale = prodFields.scale + {{positPkg::scaleWidth{1'b0}}, carry};

  // saturate the scale so the encoder lands on maxpos or minpos
  always_comb begin
    if (normScale > positPkg::maxScale) begin
      clampScale = positPkg::maxScale;
    end else if (normScale < -positPkg::maxScale) begin
      clampScale = -positPkg::maxScale;
    end else begin
      clampScale = normScale[positPkg::scaleWidth-1:0];
    end
  end

  // ==========================================================
  // regime, exponent and fraction string
  // ==========================================================
  assign regime = clampScale >>> positPkg::positEs;
  // k >= 0 gives k+1 ones, k < 0 gives -k zeros
  assign regBit = ~regime[positPkg::scaleWidth-1];
  // arithmetic shift replicates regBit, ~k is -k-1
  assign shiftAmt = regBit ? regime : ~regime;
  assign strBase = {regBit, ~regBit, clampScale[positPkg::positEs-1:0], frac,
                    {(positPkg::positWidth - 1){1'b0}}};
  assign strShift = strBase >>> shiftAmt;

  // top bits form the body, next is guard, the rest folds into sticky
  assign body = strShift[positPkg::composeTop -: positPkg::positWidth-1];
  assign guard = strShift[positPkg::composeTop-positPkg::positWidth+1];
  assign sticky = |strShift[positPkg::composeTop-positPkg::positWidth:0];

  // nearest, ties to even
  assign roundUp = guard & (sticky | body[0]);
  // cannot carry out since an all ones body always has guard clear
  assign rounded = body + roundUp;
  assign magnitude = {1'b0, rounded};

  // ==========================================================
  // special values and sign
  // ==========================================================
  always_comb begin
    if (prodFields.isNar) begin
      word = {1'b1, {(positPkg::positWidth - 1){1'b0}}};
    end else if (prodFields.isZero) begin
      word = '0;
    end else if (prodFields.sign) begin
      word = -magnitude;
    end else begin
      word = magnitude;
    end
  end

endmodule

//--- rtl/positDecompose.sv
`timescale 1ns/1ps

module positDecompose (
  input  positPkg::posit_t      word,
  output positPkg::decomposed_t fields
);

  // magnitude and the body below the sign bit
  logic [positPkg::positWidth-1:0] absWord;
  logic [positPkg::positWidth-2:0] body;
  // first regime bit, decides between ones run and zeros run
  logic regimeBit;
  logic [positPkg::runWidth-1:0] run;
  logic counting;
  logic signed [positPkg::scaleWidth-1:0] runExt;
  logic signed [positPkg::scaleWidth-1:0] regime;
  // body with regime and terminator shifted out
  logic [positPkg::positWidth-2:0] shifted;
  logic [positPkg::positEs-1:0] expBits;

  assign absWord = word[positPkg::positWidth-1] ? -word : word;
  assign body = absWord[positPkg::positWidth-2:0];
  assign regimeBit = body[positPkg::positWidth-2];

  // run length of identical bits from the top of the body
  always_comb begin
    run = '0;
    counting = 1'b1;
    for (int i = positPkg::positWidth - 2; i >= 0; i--) begin
      if (counting && (body[i] == regimeBit)) begin
        run = run + 1'b1;
      end else begin
        counting = 1'b0;
      end
    end
  end

  // ones run of m gives k = m-1, zeros run of m gives k = -m
  assign runExt = {{(positPkg::scaleWidth - positPkg::runWidth){1'b0}}, run};
  assign regime = regimeBit ? runExt - 1 : -runExt;

  // drop regime plus terminator, bits past the end read as zero
  assign shifted = body << (run + 1'b1);
  assign expBits = shifted[positPkg::positWidth-2 -: positPkg::positEs];

  always_comb begin
    fields.isZero = (word == '0);
    // NaR is the sign bit alone
    fields.isNar = (word == {1'b1, {(positPkg::positWidth - 1){1'b0}}});
    fields.sign = word[positPkg::positWidth-1];
    fields.scale = (regime <<< positPkg::positEs) +
                   {{(positPkg::scaleWidth - positPkg::positEs){1'b0}}, expBits};
    // hidden one above the fraction
    fields.sig = {1'b1,
                  shifted[positPkg::positWidth-2-positPkg::positEs -: positPkg::sigWidth-1]};
  end

endmodule

//--- rtl/positMulControl.sv
`timescale 1ns/1ps

module positMulControl (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic decEn,
  output logic mulEn,
  output logic cmpEn,
  output logic busy,
  output logic done
);

  // state names the last stage register that was loaded
  positPkg::mulState_e state;
  positPkg::mulState_e nextState;
  logic accept;

  // stCompose is the done cycle and may take a new start
  assign busy = (state == positPkg::stDecode) || (state == positPkg::stMultiply);
  // start while busy is dropped
  assign accept = start && !busy;

  // ==========================================================
  // stage enables, one cycle each
  // ==========================================================
  // operands sampled in the start cycle itself
  assign decEn = accept;
  assign mulEn = (state == positPkg::stDecode);
  assign cmpEn = (state == positPkg::stMultiply);

  always_comb begin
    nextState = state;
    case (state)
      positPkg::stIdle: begin
        if (accept) nextState = positPkg::stDecode;
      end
      positPkg::stDecode: nextState = positPkg::stMultiply;
      positPkg::stMultiply: nextState = positPkg::stCompose;
      positPkg::stCompose: begin
        // back to back operation
        nextState = accept ? positPkg::stDecode : positPkg::stIdle;
      end
      default: nextState = positPkg::stIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= positPkg::stIdle;
      done <= 1'b0;
    end else begin
      state <= nextState;
      // result loads on cmpEn, valid in the following cycle
      done <= cmpEn;
    end
  end

endmodule

//--- rtl/positMulCore.sv
`timescale 1ns/1ps

module positMulCore (
  input  positPkg::decomposed_t a,
  input  positPkg::decomposed_t b,
  output positPkg::product_t    prodFields
);

  // ==========================================================
  // special values
  // ==========================================================
  logic nar;
  logic zero;

  // NaR wins over zero
  assign nar = a.isNar | b.isNar;
  assign zero = !nar && (a.isZero || b.isZero);

  // ==========================================================
  // sign, scale and significand product
  // ==========================================================
  always_comb begin
    prodFields.isNar = nar;
    prodFields.isZero = zero;
    if (nar || zero) begin
      // payload is meaningless here, keep it quiet
      prodFields.sign = 1'b0;
      prodFields.scale = '0;
      prodFields.prod = '0;
    end else begin
      prodFields.sign = a.sign ^ b.sign;
      // sign extend both scales by one bit before the add
      prodFields.scale = {a.scale[positPkg::scaleWidth-1], a.scale} +
                         {b.scale[positPkg::scaleWidth-1], b.scale};
      // 1.f times 1.f, result in [1,4)
      prodFields.prod = a.sig * b.sig;
    end
  end

endmodule

//--- rtl/positMulUnit.sv
`timescale 1ns/1ps

module positMulUnit (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  positPkg::posit_t opA,
  input  positPkg::posit_t opB,
  output positPkg::posit_t result,
  output logic             busy,
  output logic             done
);

  logic decEn;
  logic mulEn;
  logic cmpEn;
  // combinational stage outputs and their registers
  positPkg::decomposed_t fieldsA;
  positPkg::decomposed_t fieldsB;
  positPkg::decomposed_t decA;
  positPkg::decomposed_t decB;
  positPkg::product_t prodNext;
  positPkg::product_t prodReg;
  positPkg::posit_t resultNext;

  positMulControl control (.clk(clk), .reset(reset), .start(start), .decEn(decEn),
                           .mulEn(mulEn), .cmpEn(cmpEn), .busy(busy), .done(done));

  positDecompose decomposeA (.word(opA), .fields(fieldsA));
  positDecompose decomposeB (.word(opB), .fields(fieldsB));
  positMulCore core (.a(decA), .b(decB), .prodFields(prodNext));
  positCompose compose (.prodFields(prodReg), .word(resultNext));

  // ==========================================================
  // stage registers
  // ==========================================================
  always_ff @(posedge clk) begin
    if (decEn) begin
      decA <= fieldsA;
      decB <= fieldsB;
    end
    if (mulEn) prodReg <= prodNext;
  end

  // result holds until the next completed operation
  always_ff @(posedge clk) begin
    if (reset) result <= '0;
    else if (cmpEn) result <= resultNext;
  end

endmodule

//--- rtl/positPkg.sv
package positPkg;

  // ==========================================================
  // posit16 format, es = 1
  // ==========================================================
  localparam int positWidth = 16;
  localparam int positEs = 1;
  // signed scale, wide enough for the sum of two scales
  localparam int scaleWidth = 7;
  // hidden one plus fraction
  localparam int sigWidth = positWidth - positEs - 2;
  // fraction bits below the hidden one of a full significand product
  localparam int prodFracWidth = 2 * sigWidth - 1;
  // top index of the unrounded regime/exponent/fraction string
  localparam int composeTop = positWidth + prodFracWidth + positEs;
  // regime run counter, counts up to positWidth-1 and the terminator
  localparam int runWidth = $clog2(positWidth) + 1;
  // largest scale, that of maxpos (minpos is its negation)
  localparam logic signed [scaleWidth-1:0] maxScale =
      scaleWidth'((positWidth - 2) << positEs);

  typedef logic [positWidth-1:0] posit_t;

  // one operand split into fields
  typedef struct packed {
    logic                         isZero;
    logic                         isNar;
    logic                         sign;
    logic signed [scaleWidth-1:0] scale;
    logic [sigWidth-1:0]          sig;
  } decomposed_t;

  // raw product before normalization and rounding
  typedef struct packed {
    logic                       isZero;
    logic                       isNar;
    logic                       sign;
    logic signed [scaleWidth:0] scale;
    logic [2*sigWidth-1:0]      prod;
  } product_t;

  typedef enum logic [1:0] {stIdle, stDecode, stMultiply, stCompose} mulState_e;

endpackage

//--- testbench/positMulUnitTb.sv
`timescale 1ns/1ps

module positMulUnitTb;

  // ==========================================================
  // run length
  // ==========================================================
  localparam int clockPeriod = 4;
  localparam int resetCycles = 16;
  localparam int numVectors = 14;
  localparam int numRandom = 40;
  // table, three ops per random pair, two for the dropped start
  localparam int numOps = numVectors + 3 * numRandom + 2;
  localparam int watchdogNs = (numOps * 10 + resetCycles) * clockPeriod;
  // cycles to wait for done on one operation
  localparam int maxWait = 10;

  // one table row
  typedef struct packed {
    positPkg::posit_t a;
    positPkg::posit_t b;
    positPkg::posit_t expected;
  } vector_t;

  logic clk;
  logic reset;
  logic start;
  positPkg::posit_t opA;
  positPkg::posit_t opB;
  positPkg::posit_t result;
  logic busy;
  logic done;

  vector_t vectors [numVectors];
  int checks;
  int errors;
  int seed;

  positMulUnit uut (.clk(clk), .reset(reset), .start(start), .opA(opA), .opB(opB),
                    .result(result), .busy(busy), .done(done));

  always #(clockPeriod / 2) clk = ~clk;

  // watchdog sized from the operation count
  initial begin
    #(watchdogNs);
    $display("Timeout: the tests did not finish within %0d ns", watchdogNs);
    $display("** FAIL **");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // called 1 ns after an edge with the unit able to accept
  task automatic runOp(input positPkg::posit_t a, input positPkg::posit_t b,
                       output positPkg::posit_t res, output int latency);
    int cycles;
    cycles = 0;
    opA = a;
    opB = b;
    start = 1'b1;
    do begin
      @(posedge clk);
      #1;
      start = 1'b0;
      cycles++;
      // busy from the accepting edge until the done cycle
      check("busy", cycles < 3, busy);
    end while (!done && cycles < maxWait);
    if (!done) begin
      errors++;
      $display("Operation %h times %h never raised done", a, b);
    end
    res = result;
    latency = cycles;
  endtask

  // ==========================================================
  // expected values from posit16 es=1 encoding
  // ==========================================================
  task automatic loadVectors;
    // 1.0, 2.0, 0.5 and 4.0 products
    vectors[0] = '{16'h4000, 16'h4000, 16'h4000};
    vectors[1] = '{16'h5000, 16'h5000, 16'h6000};
    vectors[2] = '{16'h3000, 16'h5000, 16'h4000};
    vectors[3] = '{16'h4800, 16'h4800, 16'h5200};
    vectors[4] = '{16'hc000, 16'h5000, 16'hb000};
    vectors[5] = '{16'hc000, 16'hc000, 16'h4000};
    vectors[6] = '{16'h3000, 16'h3000, 16'h2000};
    vectors[13] = '{16'h6000, 16'h3000, 16'h5000};
    // 1+2^-12 squared, the 2^-24 term rounds away
    vectors[7] = '{16'h4001, 16'h4001, 16'h4002};
    // zero and NaR, NaR wins
    vectors[8] = '{16'h0000, 16'h4800, 16'h0000};
    vectors[9] = '{16'h8000, 16'h4000, 16'h8000};
    vectors[10] = '{16'h0000, 16'h8000, 16'h8000};
    // saturation at maxpos and minpos
    vectors[11] = '{16'h7fff, 16'h7fff, 16'h7fff};
    vectors[12] = '{16'h0001, 16'h0001, 16'h0001};
  endtask

  task automatic tableTest;
    positPkg::posit_t res;
    int latency;
    for (int i = 0; i < numVectors; i++) begin
      runOp(vectors[i].a, vectors[i].b, res, latency);
      check("result", vectors[i].expected, res);
      check("latency", 3, latency);
    end
  endtask

  // sign rule and commutativity on random reals
  task automatic randomTest;
    positPkg::posit_t a;
    positPkg::posit_t b;
    positPkg::posit_t negA;
    positPkg::posit_t ab;
    positPkg::posit_t negAb;
    positPkg::posit_t ba;
    positPkg::posit_t expectNeg;
    int latency;
    for (int i = 0; i < numRandom; i++) begin
      a = positPkg::posit_t'($random(seed));
      b = positPkg::posit_t'($random(seed));
      // NaR has no negation, use a neighbour instead
      if (a == 16'h8000) a = 16'h8001;
      if (b == 16'h8000) b = 16'h7fff;
      negA = -a;
      runOp(a, b, ab, latency);
      check("latency", 3, latency);
      runOp(negA, b, negAb, latency);
      check("latency", 3, latency);
      runOp(b, a, ba, latency);
      check("latency", 3, latency);
      expectNeg = -ab;
      check("negated product", expectNeg, negAb);
      check("swapped product", ab, ba);
    end
  endtask

  // second start lands while busy and must be dropped
  task automatic droppedStart;
    int doneCount;
    positPkg::posit_t firstResult;
    doneCount = 0;
    firstResult = '0;
    opA = 16'h5000;
    opB = 16'h5000;
    start = 1'b1;
    @(posedge clk);
    #1;
    opA = 16'h3000;
    opB = 16'h3000;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #1;
      start = 1'b0;
      if (done) begin
        if (doneCount == 0) firstResult = result;
        doneCount++;
      end
    end
    check("done count", 1, doneCount);
    check("result", 16'h6000, firstResult);
  endtask

  // ==========================================================
  // main sequence
  // ==========================================================
  initial begin
    clk = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    opA = '0;
    opB = '0;
    checks = 0;
    errors = 0;
    seed = 32'h6659;
    loadVectors();
    repeat (resetCycles) @(posedge clk);
    #1;
    check("busy", 0, busy);
    check("done", 0, done);
    check("result", 0, result);
    reset = 1'b0;
    tableTest();
    randomTest();
    droppedStart();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             uut.handshakeChecks.assertFails);
    if (errors == 0 && uut.handshakeChecks.assertFails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- testbench/positMulUnit_sva.sv
`timescale 1ns/1ps

module positMulUnit_sva (
  input logic             clk,
  input logic             reset,
  input logic             start,
  input logic             busy,
  input logic             done,
  input positPkg::posit_t result
);

  // failed assertions, read by the testbench summary
  int assertFails = 0;

  // ==========================================================
  // handshake and timing
  // ==========================================================
  // accepted start gives done three edges later
  startToDone: assert property (@(posedge clk) disable iff (reset)
      start && !busy |-> ##3 done)
    else begin
      $error("done did not follow an accepted start by three cycles");
      assertFails++;
    end

  // control is idle once reset has been applied
  idleAfterReset: assert property (@(posedge clk) reset |=> !busy)
    else begin
      $error("busy still high after reset");
      assertFails++;
    end

  // done is a single cycle pulse
  singleDone: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      $error("done high for two cycles in a row");
      assertFails++;
    end

  // result only moves when the compose stage loads
  resultHeld: assert property (@(posedge clk) disable iff (reset) busy |-> $stable(result))
    else begin
      $error("result changed while busy");
      assertFails++;
    end

endmodule

bind positMulUnit positMulUnit_sva handshakeChecks (
  .clk(clk),
  .reset(reset),
  .start(start),
  .busy(busy),
  .done(done),
  .result(result)
);

//--- verilog.f
rtl/positPkg.sv
rtl/positDecompose.sv
rtl/positMulCore.sv
rtl/positCompose.sv
rtl/positMulControl.sv
rtl/positMulUnit.sv
testbench/positMulUnit_sva.sv
testbench/positMulUnitTb.sv
